// File: design/z80_bus_pkg.sv
`default_nettype none

package z80_bus_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0] data_t;

    // every Z80 bus strobe is active low
    typedef logic strobe_n_t;

    localparam strobe_n_t strobe_on = 1'b0;
    localparam strobe_n_t strobe_off = 1'b1;

endpackage

`default_nettype wire

// File: design/z80_cycle_pkg.sv
`default_nettype none

package z80_cycle_pkg;

    typedef enum logic [2:0] {
        cyc_none,
        cyc_m1,
        cyc_mem,
        cyc_io,
        cyc_internal,
        cyc_extended
    } mcycle_kind_t;

    // zero means the engine is not running a cycle
    typedef logic [2:0] tstate_t;

    localparam tstate_t tstate_idle = 3'd0;
    localparam tstate_t tstate_t1 = 3'd1;
    localparam tstate_t tstate_max = 3'd7;

    // stretched cycles stop counting at the top T-state instead of wrapping to idle
    function automatic tstate_t tstate_step(tstate_t t);
        return (t == tstate_max) ? t : tstate_t'(t + 1'b1);
    endfunction

    // one T-state of a counted cycle that waits in sample and ends in last
    function automatic tstate_t tstate_next(tstate_t t, tstate_t last, tstate_t sample,
                                            logic wait_n, logic extend);
        if (t == tstate_idle) begin
            return tstate_idle;
        end
        if (t >= last) begin
            return extend ? tstate_step(t) : tstate_idle;
        end
        if (t == sample && !wait_n) begin
            return t;
        end
        return tstate_step(t);
    endfunction

endpackage

`default_nettype wire

// File: design/bus_cycle_if.sv
`default_nettype none

interface bus_cycle_if
    import z80_bus_pkg::*, z80_cycle_pkg::*;
();

    addr_t     addr;
    strobe_n_t mreq_n;
    strobe_n_t iorq_n;
    strobe_n_t rd_n;
    strobe_n_t wr_n;
    strobe_n_t m1_n;
    strobe_n_t rfsh_n;
    data_t     d_out;
    logic      d_out_en;
    data_t     rdata;
    tstate_t   tstate;
    logic      extra;
    logic      done;

    modport engine (
        output addr, mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n,
        output d_out, d_out_en, rdata, tstate, extra, done
    );

    modport ctrl (
        input addr, mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n,
        input d_out, d_out_en, rdata, tstate, extra, done
    );

endinterface

`default_nettype wire

// File: design/opcode_fetch.sv
`default_nettype none

module opcode_fetch
    import z80_bus_pkg::*, z80_cycle_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        activate,
    input  addr_t       pc,
    input  addr_t       refresh_addr,
    input  data_t       d_in,
    input  logic        wait_n,
    input  logic        extend_cycle,
    bus_cycle_if.engine bus
);

    typedef enum logic [2:0] {
        st_idle,
        st_t1,
        st_t2,
        st_t3,
        st_t4,
        st_extra
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t state_next;
    tstate_t      tstate_q;
    data_t        opcode_q;
    logic         fetch;
    logic         refresh;

    always_comb begin
        state_next = state;
        case (state)
            st_t1: state_next = st_t2;
            st_t2: state_next = wait_n ? st_t3 : st_t2;
            st_t3: state_next = st_t4;
            st_t4, st_extra: state_next = extend_cycle ? st_extra : st_idle;
            default: state_next = st_idle;
        endcase
    end

    // the T-state number follows the FSM and keeps climbing while stretched
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            tstate_q <= tstate_idle;
        end else if (activate) begin
            state <= st_t1;
            tstate_q <= tstate_t1;
        end else begin
            state <= state_next;
            if (state_next == st_idle) begin
                tstate_q <= tstate_idle;
            end else if (state_next != state || state == st_extra) begin
                tstate_q <= tstate_step(tstate_q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_t2 && wait_n) begin
            opcode_q <= d_in;
        end
    end

    assign fetch = state == st_t1 || state == st_t2;
    assign refresh = state == st_t3 || state == st_t4;

    assign bus.addr     = fetch ? pc : (refresh ? refresh_addr : '0);
    assign bus.m1_n     = fetch ? strobe_on : strobe_off;
    assign bus.rd_n     = fetch ? strobe_on : strobe_off;
    assign bus.mreq_n   = (fetch || refresh) ? strobe_on : strobe_off;
    assign bus.rfsh_n   = refresh ? strobe_on : strobe_off;
    assign bus.iorq_n   = strobe_off;
    assign bus.wr_n     = strobe_off;
    assign bus.d_out    = '0;
    assign bus.d_out_en = 1'b0;
    assign bus.rdata    = opcode_q;
    assign bus.tstate   = tstate_q;
    assign bus.extra    = state == st_extra;
    assign bus.done     = state == st_t4 || state == st_extra;

    // a refresh address on the bus must never be read as an opcode
    assert property (@(posedge clk) disable iff (reset)
        !(bus.rfsh_n == strobe_on && bus.rd_n == strobe_on));

endmodule

`default_nettype wire

// File: design/mem_rd_wr.sv
`default_nettype none

module mem_rd_wr
    import z80_bus_pkg::*, z80_cycle_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        activate,
    input  addr_t       pc,
    input  data_t       d_in,
    input  data_t       wdata,
    input  logic        rd,
    input  logic        wr,
    input  logic        wait_n,
    input  logic        extend_cycle,
    bus_cycle_if.engine bus
);

    localparam tstate_t mem_sample = 3'd2;
    localparam tstate_t mem_last = 3'd3;

    tstate_t tstate_q;
    data_t   rdata_q;
    logic    active;

    always_ff @(posedge clk) begin
        if (reset) begin
            tstate_q <= tstate_idle;
        end else if (activate) begin
            tstate_q <= tstate_t1;
        end else begin
            tstate_q <= tstate_next(tstate_q, mem_last, mem_sample, wait_n, extend_cycle);
        end
    end

    // capture on the edge that leaves T2, once the wait states are over
    always_ff @(posedge clk) begin
        if (tstate_q == mem_sample && wait_n) begin
            rdata_q <= d_in;
        end
    end

    // T-states past T3 only stretch the cycle, so the bus is released there
    assign active = tstate_q != tstate_idle && tstate_q <= mem_last;

    assign bus.addr     = active ? pc : '0;
    assign bus.mreq_n   = active ? strobe_on : strobe_off;
    assign bus.rd_n     = (active && rd) ? strobe_on : strobe_off;
    assign bus.wr_n     = (active && wr && tstate_q >= 3'd2) ? strobe_on : strobe_off;
    assign bus.iorq_n   = strobe_off;
    assign bus.m1_n     = strobe_off;
    assign bus.rfsh_n   = strobe_off;
    assign bus.d_out    = wdata;
    assign bus.d_out_en = active && wr;
    assign bus.rdata    = rdata_q;
    assign bus.tstate   = tstate_q;
    assign bus.extra    = tstate_q > mem_last;
    assign bus.done     = tstate_q >= mem_last;

    assert property (@(posedge clk) disable iff (reset) activate |-> !(rd && wr));

endmodule

`default_nettype wire

// File: design/io_rd_wr.sv
`default_nettype none

module io_rd_wr
    import z80_bus_pkg::*, z80_cycle_pkg::*;
#(
    parameter int io_wait_states = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        activate,
    input  addr_t       pc,
    input  data_t       d_in,
    input  data_t       wdata,
    input  logic        rd,
    input  logic        wr,
    input  logic        wait_n,
    input  logic        extend_cycle,
    bus_cycle_if.engine bus
);

    // wait_n is looked at only in the last automatic Tw, or in T2 when there is none
    localparam tstate_t io_sample = tstate_t'(2 + io_wait_states);
    localparam tstate_t io_last = tstate_t'(3 + io_wait_states);

    tstate_t tstate_q;
    data_t   rdata_q;
    logic    active;
    logic    io_strobe;

    always_ff @(posedge clk) begin
        if (reset) begin
            tstate_q <= tstate_idle;
        end else if (activate) begin
            tstate_q <= tstate_t1;
        end else begin
            tstate_q <= tstate_next(tstate_q, io_last, io_sample, wait_n, extend_cycle);
        end
    end

    always_ff @(posedge clk) begin
        if (tstate_q == io_sample && wait_n) begin
            rdata_q <= d_in;
        end
    end

    assign active = tstate_q != tstate_idle && tstate_q <= io_last;
    assign io_strobe = active && tstate_q >= 3'd2;

    assign bus.addr     = active ? pc : '0;
    assign bus.iorq_n   = io_strobe ? strobe_on : strobe_off;
    assign bus.rd_n     = (io_strobe && rd) ? strobe_on : strobe_off;
    assign bus.wr_n     = (io_strobe && wr) ? strobe_on : strobe_off;
    assign bus.mreq_n   = strobe_off;
    assign bus.m1_n     = strobe_off;
    assign bus.rfsh_n   = strobe_off;
    assign bus.d_out    = wdata;
    assign bus.d_out_en = active && wr;
    assign bus.rdata    = rdata_q;
    assign bus.tstate   = tstate_q;
    assign bus.extra    = tstate_q > io_last;
    assign bus.done     = tstate_q >= io_last;

    // the port address gets a full T-state to settle before iorq_n falls
    assert property (@(posedge clk) disable iff (reset) activate |=> bus.iorq_n == strobe_off);

endmodule

`default_nettype wire

// File: design/mcycle_ctrl.sv
`default_nettype none

module mcycle_ctrl
    import z80_bus_pkg::*, z80_cycle_pkg::*;
#(
    parameter int io_wait_states = 1
) (
    input  logic         clk,
    input  logic         reset,
    input  addr_t        pc,
    input  addr_t        refresh_addr,
    input  data_t        d_in,
    input  data_t        wdata,
    input  logic         rd,
    input  logic         wr,
    input  logic         wait_n,
    input  logic         extend_cycle,
    input  mcycle_kind_t cycle,
    output addr_t        addr,
    output strobe_n_t    mreq_n,
    output strobe_n_t    iorq_n,
    output strobe_n_t    rd_n,
    output strobe_n_t    wr_n,
    output strobe_n_t    m1_n,
    output strobe_n_t    rfsh_n,
    output data_t        d_out,
    output logic         d_out_en,
    output data_t        rdata,
    output mcycle_kind_t mcycle,
    output tstate_t      tstate,
    output logic         extra_tstate,
    output logic         done
);

    bus_cycle_if m1_bus ();
    bus_cycle_if mem_bus ();
    bus_cycle_if io_bus ();

    tstate_t int_tstate;
    tstate_t ext_tstate;
    logic    sel_m1;
    logic    sel_mem;
    logic    sel_io;
    logic    sel_int;
    logic    sel_ext;
    logic    eng_done;

    // a new cycle is taken on the same edge that ends the current one
    opcode_fetch u_m1 (.*, .activate(done && cycle == cyc_m1), .bus(m1_bus));
    mem_rd_wr u_mem (.*, .activate(done && cycle == cyc_mem), .bus(mem_bus));
    io_rd_wr #(
        .io_wait_states(io_wait_states)
    ) u_io (.*, .activate(done && cycle == cyc_io), .bus(io_bus));

    // internal and extended cycles put nothing on the bus and never wait
    always_ff @(posedge clk) begin
        if (reset) begin
            int_tstate <= tstate_idle;
            ext_tstate <= tstate_idle;
        end else begin
            int_tstate <= (done && cycle == cyc_internal) ? tstate_t1
                : tstate_next(int_tstate, tstate_t1, tstate_idle, 1'b1, extend_cycle);
            ext_tstate <= (done && cycle == cyc_extended) ? tstate_t1
                : tstate_next(ext_tstate, tstate_t1, tstate_idle, 1'b1, extend_cycle);
        end
    end

    assign sel_m1 = m1_bus.tstate != tstate_idle;
    assign sel_mem = mem_bus.tstate != tstate_idle;
    assign sel_io = io_bus.tstate != tstate_idle;
    assign sel_int = int_tstate != tstate_idle;
    assign sel_ext = ext_tstate != tstate_idle;

    assign mcycle = sel_m1 ? cyc_m1 : sel_mem ? cyc_mem : sel_io ? cyc_io :
                    sel_int ? cyc_internal : sel_ext ? cyc_extended : cyc_none;

    assign addr     = sel_m1 ? m1_bus.addr : sel_mem ? mem_bus.addr :
                      sel_io ? io_bus.addr : '0;
    assign mreq_n   = sel_m1 ? m1_bus.mreq_n : sel_mem ? mem_bus.mreq_n :
                      sel_io ? io_bus.mreq_n : strobe_off;
    assign iorq_n   = sel_m1 ? m1_bus.iorq_n : sel_mem ? mem_bus.iorq_n :
                      sel_io ? io_bus.iorq_n : strobe_off;
    assign rd_n     = sel_m1 ? m1_bus.rd_n : sel_mem ? mem_bus.rd_n :
                      sel_io ? io_bus.rd_n : strobe_off;
    assign wr_n     = sel_m1 ? m1_bus.wr_n : sel_mem ? mem_bus.wr_n :
                      sel_io ? io_bus.wr_n : strobe_off;
    assign m1_n     = sel_m1 ? m1_bus.m1_n : sel_mem ? mem_bus.m1_n :
                      sel_io ? io_bus.m1_n : strobe_off;
    assign rfsh_n   = sel_m1 ? m1_bus.rfsh_n : sel_mem ? mem_bus.rfsh_n :
                      sel_io ? io_bus.rfsh_n : strobe_off;
    assign d_out    = sel_m1 ? m1_bus.d_out : sel_mem ? mem_bus.d_out :
                      sel_io ? io_bus.d_out : '0;
    assign d_out_en = sel_m1 ? m1_bus.d_out_en : sel_mem ? mem_bus.d_out_en :
                      sel_io ? io_bus.d_out_en : 1'b0;
    assign rdata    = sel_m1 ? m1_bus.rdata : sel_mem ? mem_bus.rdata :
                      sel_io ? io_bus.rdata : '0;

    // at most one of the two local counters is ever nonzero
    assign tstate = sel_m1 ? m1_bus.tstate : sel_mem ? mem_bus.tstate :
                    sel_io ? io_bus.tstate : int_tstate | ext_tstate;
    assign extra_tstate = sel_m1 ? m1_bus.extra : sel_mem ? mem_bus.extra :
                          sel_io ? io_bus.extra :
                          (int_tstate > tstate_t1) || (ext_tstate > tstate_t1);
    assign eng_done = sel_m1 ? m1_bus.done : sel_mem ? mem_bus.done :
                      sel_io ? io_bus.done : sel_int || sel_ext;

    // an idle unit is always ready for the next request
    assign done = (mcycle == cyc_none) || (eng_done && !extend_cycle);

    assert property (@(posedge clk) disable iff (reset)
        $onehot0({sel_m1, sel_mem, sel_io, sel_int, sel_ext}));

endmodule

`default_nettype wire

// File: design/z80_bus_unit.sv
`default_nettype none

module z80_bus_unit
    import z80_bus_pkg::*, z80_cycle_pkg::*;
#(
    parameter int io_wait_states = 1
) (
    input  logic         clk,
    input  logic         reset,
    input  addr_t        pc,
    input  addr_t        refresh_addr,
    input  data_t        d_in,
    input  data_t        wdata,
    input  logic         rd,
    input  logic         wr,
    input  logic         wait_n,
    input  logic         extend_cycle,
    input  mcycle_kind_t cycle,
    output addr_t        addr,
    output strobe_n_t    mreq_n,
    output strobe_n_t    iorq_n,
    output strobe_n_t    rd_n,
    output strobe_n_t    wr_n,
    output strobe_n_t    m1_n,
    output strobe_n_t    rfsh_n,
    output data_t        d_out,
    output logic         d_out_en,
    output data_t        rdata,
    output mcycle_kind_t mcycle,
    output tstate_t      tstate,
    output logic         extra_tstate,
    output logic         done
);

    mcycle_ctrl #(
        .io_wait_states(io_wait_states)
    ) u_ctrl (.*);

endmodule

`default_nettype wire

// File: testbench/bus_checker.sv
`default_nettype none

module bus_checker
    import z80_bus_pkg::*, z80_cycle_pkg::*;
#(
    parameter int io_wait_states = 1,
    parameter int cycles_per_test = 50,
    parameter int clk_period = 20
) (
    input  logic         clk,
    input  logic         reset,
    input  addr_t        pc,
    input  addr_t        refresh_addr,
    input  data_t        wdata,
    input  logic         rd,
    input  logic         wr,
    input  logic         wait_n,
    input  logic         extend_cycle,
    input  mcycle_kind_t cycle,
    input  addr_t        addr,
    input  strobe_n_t    mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n,
    input  data_t        d_out,
    input  logic         d_out_en,
    input  data_t        rdata,
    input  mcycle_kind_t mcycle,
    input  tstate_t      tstate,
    input  logic         extra_tstate,
    input  logic         done,
    output int           errors,
    output int           tests,
    output int           cycles_done
);

    // reference model of the running machine cycle
    mcycle_kind_t kind;
    tstate_t      t;
    data_t        rdata_exp;
    logic         latched;
    logic         was_reset;
    int           waits;
    int           stretch;
    int           len;
    int           test_errors;
    int           test_cycles;

    function automatic tstate_t last_of(mcycle_kind_t k);
        case (k)
            cyc_m1: return 3'd4;
            cyc_mem: return 3'd3;
            cyc_io: return tstate_t'(3 + io_wait_states);
            default: return 3'd1;
        endcase
    endfunction

    // internal and extended cycles never look at wait_n
    function automatic tstate_t sample_of(mcycle_kind_t k);
        case (k)
            cyc_m1, cyc_mem: return 3'd2;
            cyc_io: return tstate_t'(2 + io_wait_states);
            default: return 3'd0;
        endcase
    endfunction

    function automatic data_t responder_byte(addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h3c;
    endfunction

    function automatic logic expected_done();
        return kind == cyc_none || (t >= last_of(kind) && !extend_cycle);
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string what);
        tests++;
        $display("test %0d (%s) finished with %0d errors", tests, what, test_errors);
        test_errors = 0;
    endtask

    task automatic compare_outputs();
        tstate_t last;
        logic    extra_exp;
        logic    bus_on;
        logic    fetch;
        addr_t   addr_exp;
        logic    mreq_exp, iorq_exp, rd_exp, wr_exp, m1_exp, rfsh_exp, en_exp;
        last = last_of(kind);
        extra_exp = kind != cyc_none && t > last;
        bus_on = (kind == cyc_m1 || kind == cyc_mem || kind == cyc_io) && !extra_exp;
        fetch = t <= 3'd2;
        addr_exp = '0;
        {mreq_exp, iorq_exp, rd_exp, wr_exp, m1_exp, rfsh_exp} = 6'b111111;
        en_exp = 1'b0;
        if (bus_on && kind == cyc_m1) begin
            addr_exp = fetch ? pc : refresh_addr;
            mreq_exp = 1'b0;
            m1_exp = !fetch;
            rd_exp = !fetch;
            rfsh_exp = fetch;
        end else if (bus_on && kind == cyc_mem) begin
            addr_exp = pc;
            mreq_exp = 1'b0;
            rd_exp = !rd;
            wr_exp = !(wr && t >= 3'd2);
            en_exp = wr;
        end else if (bus_on) begin
            // T1 of an I/O cycle only puts the port address out
            addr_exp = pc;
            iorq_exp = t < 3'd2;
            rd_exp = !(rd && t >= 3'd2);
            wr_exp = !(wr && t >= 3'd2);
            en_exp = wr;
        end
        // the DUT's own T1 starts its count of T-states for the running cycle
        if (tstate === tstate_t1) begin
            len = 1;
        end else if (mcycle !== cyc_none) begin
            len++;
        end
        check_value("mcycle", 16'(kind), 16'(mcycle));
        check_value("tstate", 16'(t), 16'(tstate));
        check_value("done", 16'(expected_done()), 16'(done));
        check_value("extra_tstate", 16'(extra_exp), 16'(extra_tstate));
        check_value("mreq_n", 16'(mreq_exp), 16'(mreq_n));
        check_value("iorq_n", 16'(iorq_exp), 16'(iorq_n));
        check_value("rd_n", 16'(rd_exp), 16'(rd_n));
        check_value("wr_n", 16'(wr_exp), 16'(wr_n));
        check_value("m1_n", 16'(m1_exp), 16'(m1_n));
        check_value("rfsh_n", 16'(rfsh_exp), 16'(rfsh_n));
        check_value("d_out_en", 16'(en_exp), 16'(d_out_en));
        if (!extra_exp) begin
            check_value("addr", addr_exp, addr);
        end
        if (en_exp) begin
            check_value("d_out", 16'(wdata), 16'(d_out));
        end
        if (latched && (kind == cyc_m1 || rd)) begin
            check_value("rdata", 16'(rdata_exp), 16'(rdata));
        end else if (kind == cyc_none || kind == cyc_internal || kind == cyc_extended) begin
            check_value("rdata", 16'd0, 16'(rdata));
        end
    endtask

    task automatic finish_cycle();
        int expected_len;
        expected_len = int'(last_of(kind)) + waits + stretch;
        if (len != expected_len) begin
            $display("CHECK FAILED at time %0t: %s cycle length expected %0d, actual %0d",
                     $time, kind.name(), expected_len, len);
            errors++;
            test_errors++;
        end
        cycles_done++;
        test_cycles++;
        if (test_cycles == cycles_per_test) begin
            report_test($sformatf("%0d random machine cycles", cycles_per_test));
            test_cycles = 0;
        end
    endtask

    task automatic advance_model();
        logic    ends;
        tstate_t sample;
        ends = expected_done();
        sample = sample_of(kind);
        if (reset) begin
            kind = cyc_none;
            t = 3'd0;
        end else begin
            if (ends && kind != cyc_none) begin
                finish_cycle();
            end
            if (ends) begin
                kind = cycle;
                t = (cycle == cyc_none) ? 3'd0 : 3'd1;
                latched = 1'b0;
                waits = 0;
                stretch = 0;
                len = 0;
            end else if (t >= last_of(kind)) begin
                // stretched by extend_cycle, saturating at T7
                t = (t == 3'd7) ? t : t + 3'd1;
                stretch++;
            end else if (t == sample && !wait_n) begin
                waits++;
            end else begin
                if (t == sample) begin
                    latched = 1'b1;
                    rdata_exp = responder_byte(pc);
                end
                t = t + 3'd1;
            end
        end
    endtask

    initial begin
        errors = 0;
        tests = 0;
        cycles_done = 0;
        test_errors = 0;
        test_cycles = 0;
        kind = cyc_none;
        t = 3'd0;
        latched = 1'b0;
        rdata_exp = '0;
        waits = 0;
        stretch = 0;
        len = 0;
        was_reset = 1'b1;
        forever begin
            // sampled once per T-state, after the falling-edge stimulus has settled
            @(negedge clk);
            #(clk_period / 4);
            compare_outputs();
            if (was_reset && !reset) begin
                report_test("reset and idle");
            end
            was_reset = reset;
            advance_model();
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_z80_bus_unit.sv
`default_nettype none

module tb_z80_bus_unit
    import z80_bus_pkg::*, z80_cycle_pkg::*;
();

    localparam int io_wait_states = 1;
    localparam int clk_period = 20;
    localparam int reset_cycles = 8;
    localparam int num_cycles = 600;
    localparam int cycles_per_test = 50;
    localparam int max_waits = 3;
    localparam int max_stretch = 3;
    localparam int seed = 30;
    localparam int base_len = (3 + io_wait_states > 4) ? 3 + io_wait_states : 4;
    localparam int worst_len = base_len + max_waits + max_stretch;
    localparam int timeout_cycles = reset_cycles + num_cycles * worst_len;

    logic         clk;
    logic         reset;
    addr_t        pc;
    addr_t        refresh_addr;
    data_t        d_in;
    data_t        wdata;
    logic         rd;
    logic         wr;
    logic         wait_n;
    logic         extend_cycle;
    mcycle_kind_t cycle;
    addr_t        addr;
    strobe_n_t    mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n;
    data_t        d_out;
    logic         d_out_en;
    data_t        rdata;
    mcycle_kind_t mcycle;
    tstate_t      tstate;
    logic         extra_tstate;
    logic         done;
    int           errors;
    int           tests;
    int           cycles_done;
    int           low_run;
    int           ext_run;

    z80_bus_unit #(
        .io_wait_states(io_wait_states)
    ) dut (.*);

    bus_checker #(
        .io_wait_states(io_wait_states),
        .cycles_per_test(cycles_per_test),
        .clk_period(clk_period)
    ) u_checker (.*);

    // memory and I/O answer every read with a byte made from the address
    assign d_in = addr[7:0] ^ addr[15:8] ^ 8'h3c;

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // runs of wait_n low and of extend_cycle high are kept short
    task automatic draw_wait_and_extend();
        wait_n = !($urandom_range(3, 0) == 0 && low_run < max_waits);
        low_run = wait_n ? 0 : low_run + 1;
        extend_cycle = $urandom_range(4, 0) == 0 && ext_run < max_stretch;
        ext_run = extend_cycle ? ext_run + 1 : 0;
    endtask

    task automatic draw_request();
        logic [31:0] r;
        int          pick;
        r = $urandom;
        pick = $urandom_range(7, 0);
        case (pick)
            0: cycle = cyc_none;
            1, 2: cycle = cyc_m1;
            3, 4: cycle = cyc_mem;
            5: cycle = cyc_io;
            6: cycle = cyc_internal;
            default: cycle = cyc_extended;
        endcase
        pc = r[31:16];
        wdata = r[7:0];
        rd = r[8];
        wr = !r[8];
        if (cycle == cyc_m1) begin
            refresh_addr = refresh_addr + 16'd1;
        end
    endtask

    initial begin
        void'($urandom(seed));
        reset = 1'b1;
        pc = '0;
        refresh_addr = '0;
        wdata = '0;
        rd = 1'b0;
        wr = 1'b0;
        wait_n = 1'b1;
        extend_cycle = 1'b0;
        cycle = cyc_none;
        low_run = 0;
        ext_run = 0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        forever begin
            draw_wait_and_extend();
            // done depends on extend_cycle, so it is read once that has settled
            #1;
            if (done) begin
                draw_request();
            end
            @(negedge clk);
        end
    end

    initial begin
        wait (cycles_done >= num_cycles);
        @(negedge clk);
        $display("%0d tests, %0d machine cycles, %0d errors", tests, cycles_done, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog: only %0d of %0d machine cycles finished within %0d clock cycles",
                 cycles_done, num_cycles, timeout_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: z80_bus_unit.f
design/z80_bus_pkg.sv
design/z80_cycle_pkg.sv
design/bus_cycle_if.sv
design/opcode_fetch.sv
design/mem_rd_wr.sv
design/io_rd_wr.sv
design/mcycle_ctrl.sv
design/z80_bus_unit.sv
testbench/bus_checker.sv
testbench/tb_z80_bus_unit.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_z80_bus_unit -f z80_bus_unit.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_z80_bus_unit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
